// ==== common/uart_cmd_pkg.sv ====
`default_nettype none

package uart_cmd_pkg;

  // Serial timing.
  localparam int BIT_CYCLES      = 434;  // Clocks per bit period.
  localparam int FRAME_BITS      = 11;   // Start, 8 data, parity, stop.
  localparam int GAP_BITS        = 4;    // Idle periods between write frames.
  localparam int RX_TIMEOUT_BITS = 32;   // Periods to wait for a reply start bit.

  // Counter widths derived from the timing above.
  localparam int BIT_CNT_W   = $clog2(BIT_CYCLES);
  localparam int FRAME_CNT_W = $clog2(FRAME_BITS);
  localparam int TICK_CNT_W  = $clog2((RX_TIMEOUT_BITS > GAP_BITS) ? RX_TIMEOUT_BITS
                                                                  : GAP_BITS);

  // Bit timer reload values.
  localparam logic [BIT_CNT_W-1:0] FULL_RELOAD = BIT_CNT_W'(BIT_CYCLES - 1);
  localparam logic [BIT_CNT_W-1:0] HALF_RELOAD = BIT_CNT_W'((BIT_CYCLES - 1) / 2);

  // Last tick index within a frame, counted from zero.
  localparam logic [FRAME_CNT_W-1:0] FRAME_LAST = FRAME_CNT_W'(FRAME_BITS - 1);

  // Host command word. The upper byte goes out as the head frame.
  typedef struct packed {
    logic       wr;     // High for a write.
    logic [6:0] addr;   // Register address.
    logic [7:0] wdata;  // Write data, second frame of a write.
  } uart_cmd_t;

  // Bit timer control from the command FSM.
  typedef struct packed {
    logic restart;  // Reload the counter.
    logic half;     // First period is half length.
  } timer_ctl_t;

endpackage

`default_nettype wire

// ==== rtl/baud_timer.sv ====
`default_nettype none

module baud_timer
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  timer_ctl_t timer_ctl,
  output logic       tick
);

  logic [BIT_CNT_W-1:0] cnt;

  // A pending tick is dropped while the counter is being restarted.
  assign tick = (cnt == '0) && !timer_ctl.restart;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt <= FULL_RELOAD;
    end
    else if (timer_ctl.restart)
    begin
      cnt <= timer_ctl.half ? HALF_RELOAD : FULL_RELOAD;
    end
    else if (cnt == '0)
    begin
      cnt <= FULL_RELOAD;  // Every later period is full length.
    end
    else
    begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_tx_frame.sv ====
`default_nettype none

module uart_tx_frame
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_load,
  input  logic [7:0] tx_byte,
  input  logic       tick,
  output logic       tx,
  output logic       tx_done
);

  logic [FRAME_BITS-1:0]  frame;
  logic [FRAME_CNT_W-1:0] bit_cnt;
  logic                   busy;

  assign tx_done = busy && tick && (bit_cnt == FRAME_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      tx      <= 1'b1;  // Line idles high.
    end
    else if (tx_load)
    begin
      busy    <= 1'b1;
      bit_cnt <= '0;
      tx      <= 1'b0;  // Start bit.
    end
    else if (busy && tick)
    begin
      tx <= frame[1];  // Ones fill in behind, so the last tick leaves tx idle.
      if (tx_done)
      begin
        busy <= 1'b0;
      end
      else
      begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // Stop, even parity, data LSB first, start.
  always_ff @(posedge clk)
  begin
    if (tx_load)
    begin
      frame <= {1'b1, ^tx_byte, tx_byte, 1'b0};
    end
    else if (busy && tick)
    begin
      frame <= {1'b1, frame[FRAME_BITS-1:1]};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_rx_frame.sv ====
`default_nettype none

module uart_rx_frame
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       rx_arm,
  input  logic       tick,
  output logic       rx_start,
  output logic       rx_done,
  output logic [7:0] rx_byte,
  output logic       rx_bad
);

  logic [1:0]             rx_sync;
  logic                   rx_s;
  logic                   busy;
  logic [FRAME_CNT_W-1:0] bit_cnt;
  logic [8:0]             shreg;  // Parity in bit 8, data below it.
  logic                   sample;

  assign rx_s = rx_sync[1];

  assign rx_start = rx_arm && !busy && !rx_s;
  assign rx_done  = busy && tick && (bit_cnt == FRAME_LAST);

  // Tick 0 lands mid start bit, ticks 1 to 9 carry data and parity.
  assign sample = busy && tick && (bit_cnt != '0) && !rx_done;

  assign rx_byte = shreg[7:0];
  assign rx_bad  = (^shreg) || !rx_s;  // Odd count of ones, or a low stop bit.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_sync <= 2'b11;
    end
    else
    begin
      rx_sync <= {rx_sync[0], rx};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      bit_cnt <= '0;
    end
    else if (rx_start)
    begin
      busy    <= 1'b1;
      bit_cnt <= '0;
    end
    else if (busy && tick)
    begin
      if (rx_done)
      begin
        busy <= 1'b0;
      end
      else
      begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // LSB arrives first, so shift in from the top.
  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      shreg <= {rx_s, shreg[8:1]};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cmd_ctrl/uart_cmd_ctrl.sv ====
`default_nettype none

module uart_cmd_ctrl
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  uart_cmd_t  cmd,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  input  logic       tick,
  output timer_ctl_t timer_ctl,
  output logic       tx_load,
  output logic [7:0] tx_byte,
  input  logic       tx_done,
  output logic       rx_arm,
  input  logic       rx_start,
  input  logic       rx_done,
  input  logic [7:0] rx_byte,
  input  logic       rx_bad,
  output logic       read_rdy,
  output logic [7:0] read_data,
  output logic       read_err
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_HEAD,
    S_GAP,
    S_SEND_DATA,
    S_WAIT_REPLY,
    S_RECV_REPLY,
    S_REPORT
  } state_t;

  state_t                state;
  uart_cmd_t             cmd_q;
  logic [TICK_CNT_W-1:0] tick_cnt;
  logic                  accept;
  logic                  gap_done;
  logic                  timeout;

  assign cmd_rdy  = (state == S_IDLE);
  assign accept   = cmd_vld && cmd_rdy;
  assign rx_arm   = (state == S_WAIT_REPLY) || (state == S_RECV_REPLY);
  assign read_rdy = (state == S_REPORT);  // One cycle, then back to idle.

  assign gap_done = (state == S_GAP) && tick &&
                    (tick_cnt == TICK_CNT_W'(GAP_BITS - 1));

  // A start bit in the same cycle wins over the timeout.
  assign timeout  = (state == S_WAIT_REPLY) && !rx_start && tick &&
                    (tick_cnt == TICK_CNT_W'(RX_TIMEOUT_BITS - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= S_IDLE;
      tick_cnt  <= '0;
      timer_ctl <= '0;
      tx_load   <= 1'b0;
      read_data <= '0;
      read_err  <= 1'b0;
    end
    else
    begin
      timer_ctl <= '0;
      tx_load   <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (accept)
          begin
            state             <= S_SEND_HEAD;
            tx_load           <= 1'b1;
            timer_ctl.restart <= 1'b1;  // Align ticks to the frame start.
          end
        end
        S_SEND_HEAD:
        begin
          if (tx_done)
          begin
            tick_cnt <= '0;
            state    <= cmd_q.wr ? S_GAP : S_WAIT_REPLY;
          end
        end
        S_GAP:
        begin
          if (gap_done)
          begin
            state             <= S_SEND_DATA;
            tx_load           <= 1'b1;
            timer_ctl.restart <= 1'b1;
          end
          else if (tick)
          begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        S_SEND_DATA:
        begin
          if (tx_done)
          begin
            state <= S_IDLE;
          end
        end
        S_WAIT_REPLY:
        begin
          if (rx_start)
          begin
            state     <= S_RECV_REPLY;
            timer_ctl <= '{restart: 1'b1, half: 1'b1};  // Later ticks fall mid-bit.
          end
          else if (timeout)
          begin
            state     <= S_REPORT;
            read_data <= '0;
            read_err  <= 1'b1;
          end
          else if (tick)
          begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        S_RECV_REPLY:
        begin
          if (rx_done)
          begin
            state     <= S_REPORT;
            read_data <= rx_byte;
            read_err  <= rx_bad;
          end
        end
        S_REPORT:
        begin
          state <= S_IDLE;
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Command and outgoing byte.
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q   <= cmd;
      tx_byte <= {cmd.wr, cmd.addr};  // Head frame is the upper byte.
    end
    else if (gap_done)
    begin
      tx_byte <= cmd_q.wdata;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_cmd_master.sv ====
`default_nettype none

module uart_cmd_master
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  uart_cmd_t  cmd,
  input  logic       cmd_vld,
  input  logic       rx,
  output logic       tx,
  output logic       cmd_rdy,
  output logic       read_rdy,
  output logic [7:0] read_data,
  output logic       read_err
);

  timer_ctl_t timer_ctl;
  logic       tick;
  logic       tx_load;
  logic [7:0] tx_byte;
  logic       tx_done;
  logic       rx_arm;
  logic       rx_start;
  logic       rx_done;
  logic [7:0] rx_byte;
  logic       rx_bad;

  uart_cmd_ctrl uart_cmd_ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tick      (tick),
    .timer_ctl (timer_ctl),
    .tx_load   (tx_load),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_arm    (rx_arm),
    .rx_start  (rx_start),
    .rx_done   (rx_done),
    .rx_byte   (rx_byte),
    .rx_bad    (rx_bad),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  baud_timer baud_timer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .timer_ctl (timer_ctl),
    .tick      (tick)
  );

  uart_tx_frame uart_tx_frame_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_load (tx_load),
    .tx_byte (tx_byte),
    .tick    (tick),
    .tx      (tx),
    .tx_done (tx_done)
  );

  uart_rx_frame uart_rx_frame_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_arm   (rx_arm),
    .tick     (tick),
    .rx_start (rx_start),
    .rx_done  (rx_done),
    .rx_byte  (rx_byte),
    .rx_bad   (rx_bad)
  );

endmodule

`default_nettype wire

// ==== tests/tb_uart_cmd_master.sv ====
`default_nettype none

module tb_uart_cmd_master
  import uart_cmd_pkg::*;
();

  localparam int WRITE_CYCLES = (2 * FRAME_BITS + GAP_BITS) * BIT_CYCLES + 2;
  localparam int READ_CYCLES  = (2 * FRAME_BITS + RX_TIMEOUT_BITS) * BIT_CYCLES;
  localparam int IDLE_CYCLES  = 2 * BIT_CYCLES;
  localparam int POKE_CYCLE   = 3 * BIT_CYCLES;  // Inside the head frame of a write.
  localparam int N_WRITES     = 3;
  localparam int N_READS      = 5;
  localparam int CYCLE_LIMIT  = N_WRITES * (WRITE_CYCLES + 2 * IDLE_CYCLES) +
                                N_READS * (READ_CYCLES + IDLE_CYCLES) + 10 * BIT_CYCLES;

  localparam int MODE_NORMAL     = 0;
  localparam int MODE_BAD_PARITY = 1;
  localparam int MODE_SILENT     = 2;

  logic       clk;
  logic       rst_n;
  uart_cmd_t  cmd;
  logic       cmd_vld;
  logic       rx;
  logic       tx;
  logic       cmd_rdy;
  logic       read_rdy;
  logic [7:0] read_data;
  logic       read_err;

  logic [31:0] rand_state = 32'd88297;
  logic [7:0]  regs [128];         // Register file of the serial device.
  logic [7:0]  frame_q [$];        // Bytes decoded from tx.
  int          frames_started = 0;
  int          reply_mode = 0;
  int          reply_delay = 1;    // Bit periods before the reply start bit.

  uart_cmd_master uart_cmd_master_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  task automatic run_failed(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    run_failed($sformatf("Mismatch at time %0t: %s is 0x%0h, expected 0x%0h",
                         $time, name, got, exp));
  endtask

  // Returns on the negedge after the accepting edge.
  task automatic issue_cmd(input uart_cmd_t c);
    @(negedge clk);
    assert (cmd_rdy) else run_failed("DUT was not ready for a new command");
    @(posedge clk);
    cmd     <= c;
    cmd_vld <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    assert (!cmd_rdy) else mismatch("cmd_rdy after accept", 32'(cmd_rdy), 32'd0);
  endtask

  task automatic run_write(input logic [6:0] addr, input logic [7:0] data, input logic poke);
    uart_cmd_t c;
    int        base;
    int        cycles;
    logic      rdy_seen;
    c.wr     = 1'b1;
    c.addr   = addr;
    c.wdata  = data;
    base     = frames_started;
    issue_cmd(c);
    cycles   = 0;
    rdy_seen = 1'b0;
    while (!rdy_seen)
    begin
      @(posedge clk);
      cycles++;
      cmd_vld <= poke && (cycles == POKE_CYCLE);  // Busy DUT must drop this.
      @(negedge clk);
      rdy_seen = cmd_rdy;
    end
    assert (cycles == WRITE_CYCLES)
      else mismatch("cmd_rdy latency", 32'(cycles), 32'(WRITE_CYCLES));
    assert (frames_started - base == 2)
      else mismatch("tx frame count", 32'(frames_started - base), 32'd2);
    assert (frame_q[base] == {1'b1, addr})
      else mismatch("tx head byte", 32'(frame_q[base]), 32'({1'b1, addr}));
    assert (frame_q[base + 1] == data)
      else mismatch("tx data byte", 32'(frame_q[base + 1]), 32'(data));
    repeat (IDLE_CYCLES) @(posedge clk);
    assert (frames_started - base == 2)
      else mismatch("tx frame count after idle", 32'(frames_started - base), 32'd2);
  endtask

  task automatic run_read(input logic [6:0] addr, input int mode, input int delay);
    uart_cmd_t   c;
    logic [31:0] rnd;
    int          base;
    logic        done;
    rnd         = next_rand();
    c.wr        = 1'b0;
    c.addr      = addr;
    c.wdata     = rnd[23:16];  // Not sent for a read.
    reply_mode  = mode;
    reply_delay = delay;
    base        = frames_started;
    issue_cmd(c);
    done = 1'b0;
    while (!done)
    begin
      @(posedge clk);
      cmd_vld <= 1'b0;
      @(negedge clk);
      done = read_rdy;
      assert (done || !cmd_rdy) else run_failed("cmd_rdy rose before the read_rdy pulse");
    end
    assert (frames_started - base == 1)
      else mismatch("tx frame count", 32'(frames_started - base), 32'd1);
    assert (frame_q[base] == {1'b0, addr})
      else mismatch("tx head byte", 32'(frame_q[base]), 32'({1'b0, addr}));
    assert (tx) else mismatch("tx", 32'(tx), 32'd1);
    if (mode == MODE_NORMAL)
    begin
      assert (!read_err) else mismatch("read_err", 32'(read_err), 32'd0);
      assert (read_data == regs[addr])
        else mismatch("read_data", 32'(read_data), 32'(regs[addr]));
    end
    else
    begin
      assert (read_err) else mismatch("read_err", 32'(read_err), 32'd1);
      if (mode == MODE_SILENT)
      begin
        assert (read_data == 8'h00) else mismatch("read_data", 32'(read_data), 32'd0);
      end
    end
    @(negedge clk);
    assert (!read_rdy) else mismatch("read_rdy", 32'(read_rdy), 32'd0);
    assert (cmd_rdy) else mismatch("cmd_rdy after read", 32'(cmd_rdy), 32'd1);
    repeat (IDLE_CYCLES) @(posedge clk);
  endtask

  // Serial device. Decodes tx at mid-bit and answers read heads on rx.
  initial
  begin : device_model
    logic [7:0]  data;
    logic        start_b;
    logic        par_b;
    logic        stop_b;
    logic [10:0] reply;
    logic        expect_data;
    rx <= 1'b1;
    expect_data = 1'b0;
    forever
    begin
      @(negedge clk);
      if (tx == 1'b0)
      begin
        frames_started++;
        repeat (BIT_CYCLES / 2) @(negedge clk);
        start_b = tx;
        for (int i = 0; i < 8; i++)
        begin
          repeat (BIT_CYCLES) @(negedge clk);
          data = {tx, data[7:1]};  // LSB first.
        end
        repeat (BIT_CYCLES) @(negedge clk);
        par_b = tx;
        repeat (BIT_CYCLES) @(negedge clk);
        stop_b = tx;
        assert (start_b == 1'b0) else mismatch("tx start bit", 32'(start_b), 32'd0);
        assert (par_b == ^data) else mismatch("tx parity bit", 32'(par_b), 32'(^data));
        assert (stop_b == 1'b1) else mismatch("tx stop bit", 32'(stop_b), 32'd1);
        frame_q.push_back(data);
        if (expect_data)
        begin
          expect_data = 1'b0;
        end
        else if (data[7])
        begin
          expect_data = 1'b1;  // Write data frame follows.
        end
        else if (reply_mode != MODE_SILENT)
        begin
          reply = {1'b1, ^regs[data[6:0]], regs[data[6:0]], 1'b0};
          if (reply_mode == MODE_BAD_PARITY)
          begin
            reply[9] = ~reply[9];
          end
          repeat (reply_delay * BIT_CYCLES) @(posedge clk);
          for (int i = 0; i < FRAME_BITS; i++)
          begin
            rx <= reply[0];
            reply = {1'b1, reply[10:1]};
            repeat (BIT_CYCLES) @(posedge clk);
          end
        end
      end
    end
  end

  initial
  begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt <= CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    run_failed("Timeout: the run did not finish within the cycle limit");
  end

  initial
  begin : stimulus
    logic [31:0] rnd;
    rst_n   <= 1'b0;
    cmd     <= '0;
    cmd_vld <= 1'b0;
    for (int a = 0; a < 128; a++)
    begin
      rnd = next_rand();
      regs[a[6:0]] = rnd[23:16];
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (cmd_rdy) else mismatch("cmd_rdy", 32'(cmd_rdy), 32'd1);
    assert (tx) else mismatch("tx", 32'(tx), 32'd1);
    assert (!read_rdy) else mismatch("read_rdy", 32'(read_rdy), 32'd0);
    assert (!read_err) else mismatch("read_err", 32'(read_err), 32'd0);
    assert (read_data == 8'h00) else mismatch("read_data", 32'(read_data), 32'd0);
    for (int n = 0; n < N_WRITES; n++)
    begin
      rnd = next_rand();
      run_write(rnd[30:24], rnd[23:16], n == 1);
    end
    for (int n = 0; n < N_READS; n++)
    begin
      rnd = next_rand();
      run_read(rnd[30:24],
               (n < 3) ? MODE_NORMAL : ((n == 3) ? MODE_BAD_PARITY : MODE_SILENT),
               1 + int'(rnd[19:16]));
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
common/uart_cmd_pkg.sv
rtl/baud_timer.sv
rtl/uart_tx_frame.sv
rtl/uart_rx_frame.sv
rtl/cmd_ctrl/uart_cmd_ctrl.sv
rtl/uart_cmd_master.sv
tests/tb_uart_cmd_master.sv

// ==== Makefile ====
TOP = tb_uart_cmd_master

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
